// ==== filelist.f ====
rtl/csr_pkg.sv
rtl/csr_timer_irq.sv
rtl/csr_trap_ctrl.sv
rtl/csr_regfile.sv
rtl/csr_stage.sv
verification/csr_stage_tb.sv

// ==== rtl/csr_pkg.sv ====
package csr_pkg;

    // Data and CSR address widths
    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    // Stage command, CSR_X is a bubble
    typedef enum logic [2:0] {
        CSR_X     = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5
    } csr_cmd_e;

    // Only U and M are implemented
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_M = 2'd3
    } priv_mode_e;

    // Machine trap setup
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS  = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MISA     = 12'h301;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIE      = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;

    // Machine trap handling
    localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_MIP      = 12'h344;

    // Machine information, read-only range
    localparam logic [CSR_ADDR_W-1:0] CSR_MHARTID  = 12'hF14;

    // mstatus fields
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;

    // mie fields, mip uses the same positions for its pending bits
    localparam int MIE_MSIE_BIT = 3;
    localparam int MIE_MTIE_BIT = 7;
    localparam int MIE_MEIE_BIT = 11;

    // MXL = 1 for RV32, extension bits A (0), I (8) and M (12)
    localparam logic [XLEN-1:0] MISA_VALUE    = 32'h4000_1101;

    // Single hart system
    localparam logic [XLEN-1:0] MHARTID_VALUE = 32'h0000_0000;

    // Interrupt flag set, exception code 7
    localparam logic [XLEN-1:0] MCAUSE_MTI    = 32'h8000_0007;

    // Environment call from U is 8, from M is 11
    localparam logic [XLEN-1:0] MCAUSE_ECALL_BASE = 32'd8;

endpackage

// ==== rtl/csr_regfile.sv ====
`timescale 1ns/100ps

module csr_regfile (
    input  logic                            clk,
    input  logic                            arst_n,
    input  csr_pkg::csr_cmd_e               access_cmd,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  csr_addr,
    input  logic [csr_pkg::XLEN-1:0]        op1_data,
    input  logic [csr_pkg::XLEN-1:0]        fetch_pc,
    input  csr_pkg::priv_mode_e             mode,
    input  logic                            mtip,
    input  logic                            take_irq,
    input  logic                            take_ecall,
    input  logic                            take_mret,
    output logic [csr_pkg::XLEN-1:0]        csr_rdata,
    output logic [csr_pkg::XLEN-1:0]        mtvec,
    output logic [csr_pkg::XLEN-1:0]        mepc,
    output csr_pkg::priv_mode_e             mstatus_mpp,
    output logic                            mstatus_mie,
    output logic                            mie_mtie
);

    import csr_pkg::*;

    // Implemented CSR state
    logic            mstatus_mpie;
    logic            mie_meie;
    logic            mie_msie;
    logic [XLEN-1:0] mscratch;
    logic [XLEN-1:0] mcause;

    // Access check and read path
    logic            is_rw;
    logic            can_read;
    logic            can_write;
    logic [XLEN-1:0] rdata_mux;

    // Write stage
    csr_cmd_e              save_cmd;
    logic                  save_ok;
    logic                  save_rw;
    logic [CSR_ADDR_W-1:0] save_addr;
    logic [XLEN-1:0]       save_op1;
    logic [XLEN-1:0]       wdata;

    // MPP is WARL, anything but U maps to M
    function automatic priv_mode_e legal_mpp(input logic [1:0] field);
        return (field == PRIV_U) ? PRIV_U : PRIV_M;
    endfunction

    assign is_rw = access_cmd inside {CSR_W, CSR_S, CSR_C};

    // Address bits 9:8 give the lowest mode allowed, 11:10 == 3 is read-only
    assign can_read  = is_rw && (csr_addr[9:8] <= mode);
    assign can_write = can_read && (csr_addr[11:10] != 2'b11);

    always_comb begin
        rdata_mux = '0;
        case (csr_addr)
            CSR_MSTATUS: begin
                rdata_mux[MSTATUS_MIE_BIT]                    = mstatus_mie;
                rdata_mux[MSTATUS_MPIE_BIT]                   = mstatus_mpie;
                rdata_mux[MSTATUS_MPP_LSB +: 2]               = mstatus_mpp;
            end
            CSR_MISA:     rdata_mux = MISA_VALUE;
            CSR_MHARTID:  rdata_mux = MHARTID_VALUE;
            CSR_MIE: begin
                rdata_mux[MIE_MEIE_BIT] = mie_meie;
                rdata_mux[MIE_MTIE_BIT] = mie_mtie;
                rdata_mux[MIE_MSIE_BIT] = mie_msie;
            end
            CSR_MTVEC:    rdata_mux = mtvec;
            CSR_MSCRATCH: rdata_mux = mscratch;
            CSR_MEPC:     rdata_mux = mepc;
            CSR_MCAUSE:   rdata_mux = mcause;
            // MTIP sits at the same position as MTIE
            CSR_MIP:      rdata_mux[MIE_MTIE_BIT] = mtip;
            default:      rdata_mux = '0;
        endcase
    end

    // Read stage, denied or unimplemented reads return 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            csr_rdata <= '0;
            save_cmd  <= CSR_X;
            save_ok   <= 1'b0;
        end else begin
            csr_rdata <= can_read ? rdata_mux : '0;
            save_cmd  <= access_cmd;
            save_ok   <= can_write;
        end
    end

    always_ff @(posedge clk) begin
        save_addr <= csr_addr;
        save_op1  <= op1_data;
    end

    assign save_rw = save_cmd inside {CSR_W, CSR_S, CSR_C};

    // Modify step on the registered old value
    always_comb begin
        case (save_cmd)
            CSR_W:   wdata = save_op1;
            CSR_S:   wdata = csr_rdata | save_op1;
            CSR_C:   wdata = csr_rdata & ~save_op1;
            default: wdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= PRIV_M;
            mie_meie     <= 1'b0;
            mie_mtie     <= 1'b0;
            mie_msie     <= 1'b0;
            mtvec        <= '0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
        end else begin
            if (save_ok) begin
                case (save_addr)
                    CSR_MSTATUS: begin
                        mstatus_mie  <= wdata[MSTATUS_MIE_BIT];
                        mstatus_mpie <= wdata[MSTATUS_MPIE_BIT];
                        mstatus_mpp  <= legal_mpp(wdata[MSTATUS_MPP_LSB +: 2]);
                    end
                    CSR_MIE: begin
                        mie_meie <= wdata[MIE_MEIE_BIT];
                        mie_mtie <= wdata[MIE_MTIE_BIT];
                        mie_msie <= wdata[MIE_MSIE_BIT];
                    end
                    CSR_MTVEC:    mtvec    <= wdata;
                    CSR_MSCRATCH: mscratch <= wdata;
                    CSR_MEPC:     mepc     <= wdata;
                    CSR_MCAUSE:   mcause   <= wdata;
                    // misa and mip ignore writes
                    default: ;
                endcase
            end

            // Trap updates come last and override a pending write
            if (take_irq) begin
                mstatus_mpp  <= mode;
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;
                mepc         <= fetch_pc;
                mcause       <= MCAUSE_MTI;
            end else if (take_ecall) begin
                mcause <= MCAUSE_ECALL_BASE + XLEN'(mode);
            end else if (take_mret) begin
                mstatus_mie  <= mstatus_mpie;
                mstatus_mpie <= 1'b1;
                mstatus_mpp  <= PRIV_U;
            end
        end
    end

    a_ro_no_write: assert property (
        @(posedge clk) disable iff (!arst_n)
        (save_rw && (save_addr[11:10] == 2'b11) && !take_irq && !take_ecall && !take_mret)
        |=> $stable({mstatus_mie, mstatus_mpie, mstatus_mpp, mie_meie, mie_mtie, mie_msie,
                     mtvec, mscratch, mepc, mcause})
    ) else $error("write to read-only CSR 0x%03h changed state", $past(save_addr));

endmodule

// ==== rtl/csr_stage.sv ====
`timescale 1ns/100ps

module csr_stage (
    input  logic                            clk,
    input  logic                            arst_n,
    input  csr_pkg::csr_cmd_e               csr_cmd,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  csr_addr,
    input  logic [csr_pkg::XLEN-1:0]        op1_data,
    input  logic                            flush,
    input  logic                            interrupt_ready,
    input  logic [csr_pkg::XLEN-1:0]        fetch_pc,
    input  logic [63:0]                     mtime,
    input  logic [63:0]                     mtimecmp,
    output csr_pkg::csr_cmd_e               csr_cmd_out,
    output logic [csr_pkg::XLEN-1:0]        csr_rdata,
    output logic [csr_pkg::XLEN-1:0]        trap_vector,
    output logic                            stall_may_interrupt
);

    import csr_pkg::*;

    csr_cmd_e        access_cmd;
    priv_mode_e      mode;
    priv_mode_e      mstatus_mpp;
    logic            take_irq;
    logic            take_ecall;
    logic            take_mret;
    logic            mtip;
    logic            mstatus_mie;
    logic            mie_mtie;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;

    // Pending interrupt doubles as the upstream stall request
    csr_timer_irq u_timer_irq (
        .mtime       (mtime),
        .mtimecmp    (mtimecmp),
        .mode        (mode),
        .mstatus_mie (mstatus_mie),
        .mie_mtie    (mie_mtie),
        .mtip        (mtip),
        .irq_pending (stall_may_interrupt)
    );

    csr_trap_ctrl u_trap_ctrl (
        .clk             (clk),
        .arst_n          (arst_n),
        .csr_cmd         (csr_cmd),
        .flush           (flush),
        .interrupt_ready (interrupt_ready),
        .irq_pending     (stall_may_interrupt),
        .mtvec           (mtvec),
        .mepc            (mepc),
        .mstatus_mpp     (mstatus_mpp),
        .access_cmd      (access_cmd),
        .take_irq        (take_irq),
        .take_ecall      (take_ecall),
        .take_mret       (take_mret),
        .mode            (mode),
        .csr_cmd_out     (csr_cmd_out),
        .trap_vector     (trap_vector)
    );

    csr_regfile u_regfile (
        .clk         (clk),
        .arst_n      (arst_n),
        .access_cmd  (access_cmd),
        .csr_addr    (csr_addr),
        .op1_data    (op1_data),
        .fetch_pc    (fetch_pc),
        .mode        (mode),
        .mtip        (mtip),
        .take_irq    (take_irq),
        .take_ecall  (take_ecall),
        .take_mret   (take_mret),
        .csr_rdata   (csr_rdata),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .mstatus_mpp (mstatus_mpp),
        .mstatus_mie (mstatus_mie),
        .mie_mtie    (mie_mtie)
    );

endmodule

// ==== rtl/csr_timer_irq.sv ====
`timescale 1ns/100ps

module csr_timer_irq (
    input  logic [63:0]          mtime,
    input  logic [63:0]          mtimecmp,
    input  csr_pkg::priv_mode_e  mode,
    input  logic                 mstatus_mie,
    input  logic                 mie_mtie,
    output logic                 mtip,
    output logic                 irq_pending
);

    import csr_pkg::*;

    logic global_en;

    // Timer pending as soon as mtime reaches the compare value
    assign mtip = (mtime >= mtimecmp);

    // Lower mode always takes M interrupts, M mode only with MIE set
    assign global_en = (mode == PRIV_U) || mstatus_mie;

    // Also feeds the early stall request, so no register in this path
    assign irq_pending = mtip && mie_mtie && global_en;

    a_pend_needs_mtip: assert final (!irq_pending || mtip)
        else $error("irq_pending high without mtip");

endmodule

// ==== rtl/csr_trap_ctrl.sv ====
`timescale 1ns/100ps

module csr_trap_ctrl (
    input  logic                        clk,
    input  logic                        arst_n,
    input  csr_pkg::csr_cmd_e           csr_cmd,
    input  logic                        flush,
    input  logic                        interrupt_ready,
    input  logic                        irq_pending,
    input  logic [csr_pkg::XLEN-1:0]    mtvec,
    input  logic [csr_pkg::XLEN-1:0]    mepc,
    input  csr_pkg::priv_mode_e         mstatus_mpp,
    output csr_pkg::csr_cmd_e           access_cmd,
    output logic                        take_irq,
    output logic                        take_ecall,
    output logic                        take_mret,
    output csr_pkg::priv_mode_e         mode,
    output csr_pkg::csr_cmd_e           csr_cmd_out,
    output logic [csr_pkg::XLEN-1:0]    trap_vector
);

    import csr_pkg::*;

    csr_cmd_e cmd_in;
    csr_cmd_e cmd_next;

    // Flushed commands become bubbles
    assign cmd_in = flush ? CSR_X : csr_cmd;

    // Timer interrupt wins over everything else in the stage
    assign take_irq = irq_pending && interrupt_ready;

    // Incoming command is dropped while an interrupt is taken
    assign access_cmd = take_irq ? CSR_X : cmd_in;

    assign take_ecall = (access_cmd == CSR_ECALL);
    assign take_mret  = (access_cmd == CSR_MRET);

    // Interrupt shows up downstream as a trap like ECALL
    assign cmd_next = take_irq ? CSR_ECALL : access_cmd;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            csr_cmd_out <= CSR_X;
        end else begin
            csr_cmd_out <= cmd_next;
        end
    end

    // Mode and redirect target
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode        <= PRIV_M;
            trap_vector <= '0;
        end else begin
            if (take_irq || take_ecall) begin
                trap_vector <= mtvec;
                mode        <= PRIV_M;
            end else if (take_mret) begin
                // Return to the mode saved at trap entry
                trap_vector <= mepc;
                mode        <= mstatus_mpp;
            end
        end
    end

    // MPP legalization in the register file keeps mode in {U, M}
    a_mode_legal: assert property (
        @(posedge clk) disable iff (!arst_n)
        mode inside {PRIV_M, PRIV_U}
    ) else $error("illegal privilege mode %0d", mode);

    a_one_strobe: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0({take_irq, take_ecall, take_mret})
    ) else $error("more than one trap strobe high");

endmodule

// ==== verification/csr_stage_tb.sv ====
`timescale 1ns/100ps

module csr_stage_tb;

    import csr_pkg::*;

    // Run limit at about ten times the test length
    localparam int TEST_CYCLES = 200;
    localparam int MAX_CYCLES  = 10 * TEST_CYCLES;
    localparam logic [XLEN-1:0] MIE_MASK = 32'h0000_0888;

    logic                  clk = 1'b0;
    logic                  arst_n;
    csr_cmd_e              csr_cmd;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic [XLEN-1:0]       op1_data;
    logic                  flush;
    logic                  interrupt_ready;
    logic [XLEN-1:0]       fetch_pc;
    logic [63:0]           mtime;
    logic [63:0]           mtimecmp;
    csr_cmd_e              csr_cmd_out;
    logic [XLEN-1:0]       csr_rdata;
    logic [XLEN-1:0]       trap_vector;
    logic                  stall_may_interrupt;

    // Reference model state
    priv_mode_e      m_mode;
    priv_mode_e      m_mpp;
    logic            m_mie;
    logic            m_mpie;
    logic [XLEN-1:0] m_ie;
    logic [XLEN-1:0] m_mtvec;
    logic [XLEN-1:0] m_mscratch;
    logic [XLEN-1:0] m_mepc;
    logic [XLEN-1:0] m_mcause;
    csr_cmd_e        exp_cmd_out;
    logic [XLEN-1:0] exp_rdata;
    logic [XLEN-1:0] exp_tvec;
    logic            exp_stall;

    int          errors       = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          err_at_start = 0;
    int          cycle_count  = 0;
    logic [31:0] lcg_state    = 32'd69260;

    always #5 clk = ~clk;

    csr_stage u_csr_stage (
        .clk                 (clk),
        .arst_n              (arst_n),
        .csr_cmd             (csr_cmd),
        .csr_addr            (csr_addr),
        .op1_data            (op1_data),
        .flush               (flush),
        .interrupt_ready     (interrupt_ready),
        .fetch_pc            (fetch_pc),
        .mtime               (mtime),
        .mtimecmp            (mtimecmp),
        .csr_cmd_out         (csr_cmd_out),
        .csr_rdata           (csr_rdata),
        .trap_vector         (trap_vector),
        .stall_may_interrupt (stall_may_interrupt)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [XLEN-1:0] model_read(input logic [CSR_ADDR_W-1:0] addr);
        logic [XLEN-1:0] v;
        v = '0;
        case (addr)
            CSR_MSTATUS: begin
                v[MSTATUS_MIE_BIT]      = m_mie;
                v[MSTATUS_MPIE_BIT]     = m_mpie;
                v[MSTATUS_MPP_LSB +: 2] = m_mpp;
            end
            CSR_MISA:     v = MISA_VALUE;
            CSR_MHARTID:  v = MHARTID_VALUE;
            CSR_MIE:      v = m_ie;
            CSR_MTVEC:    v = m_mtvec;
            CSR_MSCRATCH: v = m_mscratch;
            CSR_MEPC:     v = m_mepc;
            CSR_MCAUSE:   v = m_mcause;
            CSR_MIP:      v[MIE_MTIE_BIT] = (mtime >= mtimecmp);
            default:      v = '0;
        endcase
        return v;
    endfunction

    task automatic model_write(input logic [CSR_ADDR_W-1:0] addr, input logic [XLEN-1:0] v);
        case (addr)
            CSR_MSTATUS: begin
                m_mie  = v[MSTATUS_MIE_BIT];
                m_mpie = v[MSTATUS_MPIE_BIT];
                m_mpp  = (v[MSTATUS_MPP_LSB +: 2] == 2'd0) ? PRIV_U : PRIV_M;
            end
            CSR_MIE:      m_ie       = v & MIE_MASK;
            CSR_MTVEC:    m_mtvec    = v;
            CSR_MSCRATCH: m_mscratch = v;
            CSR_MEPC:     m_mepc     = v;
            CSR_MCAUSE:   m_mcause   = v;
            default: ;
        endcase
    endtask

    assign exp_stall = (mtime >= mtimecmp) && m_ie[MIE_MTIE_BIT]
                       && ((m_mode == PRIV_U) || m_mie);

    // Writes land in the model at the sampling edge
    always @(posedge clk or negedge arst_n) begin : ref_model
        csr_cmd_e        cmd;
        logic            irq;
        logic [XLEN-1:0] old_val;
        logic [XLEN-1:0] new_val;
        if (!arst_n) begin
            m_mode      = PRIV_M;
            m_mpp       = PRIV_M;
            m_mie       = 1'b0;
            m_mpie      = 1'b0;
            m_ie        = '0;
            m_mtvec     = '0;
            m_mscratch  = '0;
            m_mepc      = '0;
            m_mcause    = '0;
            exp_cmd_out = CSR_X;
            exp_rdata   = '0;
            exp_tvec    = '0;
        end else begin
            irq = exp_stall && interrupt_ready;
            cmd = (flush || irq) ? CSR_X : csr_cmd;
            exp_rdata = '0;
            if ((cmd inside {CSR_W, CSR_S, CSR_C}) && (csr_addr[9:8] <= m_mode)) begin
                old_val   = model_read(csr_addr);
                exp_rdata = old_val;
                case (cmd)
                    CSR_W:   new_val = op1_data;
                    CSR_S:   new_val = old_val | op1_data;
                    default: new_val = old_val & ~op1_data;
                endcase
                if (csr_addr[11:10] != 2'b11) begin
                    model_write(csr_addr, new_val);
                end
            end
            exp_cmd_out = irq ? CSR_ECALL : cmd;
            if (irq) begin
                m_mpp    = m_mode;
                m_mpie   = m_mie;
                m_mie    = 1'b0;
                m_mepc   = fetch_pc;
                m_mcause = MCAUSE_MTI;
                exp_tvec = m_mtvec;
                m_mode   = PRIV_M;
            end else if (cmd == CSR_ECALL) begin
                m_mcause = MCAUSE_ECALL_BASE + {30'd0, m_mode};
                exp_tvec = m_mtvec;
                m_mode   = PRIV_M;
            end else if (cmd == CSR_MRET) begin
                exp_tvec = m_mepc;
                m_mode   = m_mpp;
                m_mie    = m_mpie;
                m_mpie   = 1'b1;
                m_mpp    = PRIV_U;
            end
        end
    end

    // Outputs compared on the falling edge
    a_cmd_out: assert property (@(negedge clk) disable iff (!arst_n)
        csr_cmd_out == exp_cmd_out)
    else begin
        errors++;
        $display("Error at %0t: csr_cmd_out expected %s, got %s",
                 $time, exp_cmd_out.name(), csr_cmd_out.name());
    end

    a_rdata: assert property (@(negedge clk) disable iff (!arst_n) csr_rdata == exp_rdata)
    else begin
        errors++;
        $display("Error at %0t: csr_rdata expected 0x%08h, got 0x%08h",
                 $time, exp_rdata, csr_rdata);
    end

    a_tvec: assert property (@(negedge clk) disable iff (!arst_n) trap_vector == exp_tvec)
    else begin
        errors++;
        $display("Error at %0t: trap_vector expected 0x%08h, got 0x%08h",
                 $time, exp_tvec, trap_vector);
    end

    a_stall: assert property (@(negedge clk) disable iff (!arst_n)
        stall_may_interrupt == exp_stall)
    else begin
        errors++;
        $display("Error at %0t: stall_may_interrupt expected %0b, got %0b",
                 $time, exp_stall, stall_may_interrupt);
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not end within %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // One command followed by a bubble
    task automatic issue(input csr_cmd_e cmd, input logic [CSR_ADDR_W-1:0] addr,
                         input logic [XLEN-1:0] op1, input logic flushed);
        @(posedge clk);
        #1;
        csr_cmd  = cmd;
        csr_addr = addr;
        op1_data = op1;
        flush    = flushed;
        @(posedge clk);
        #1;
        csr_cmd  = CSR_X;
        csr_addr = '0;
        op1_data = '0;
        flush    = 1'b0;
    endtask

    task automatic read_csr(input logic [CSR_ADDR_W-1:0] addr);
        issue(CSR_S, addr, '0, 1'b0);
    endtask

    task automatic begin_test();
        err_at_start = errors;
    endtask

    task automatic end_test(input string name);
        repeat (2) @(posedge clk);
        tests_run++;
        if (errors != err_at_start) begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, errors - err_at_start);
        end else begin
            $display("Test %s: passed", name);
        end
    endtask

    initial begin
        logic [XLEN-1:0] val;
        arst_n          = 1'b0;
        csr_cmd         = CSR_X;
        csr_addr        = '0;
        op1_data        = '0;
        flush           = 1'b0;
        interrupt_ready = 1'b0;
        fetch_pc        = '0;
        mtime           = 64'd0;
        mtimecmp        = '1;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;

        begin_test();
        repeat (3) @(posedge clk);
        end_test("reset");

        begin_test();
        val = lcg_next();
        issue(CSR_W, CSR_MSCRATCH, val, 1'b0);
        read_csr(CSR_MSCRATCH);
        val = lcg_next() & ~32'h3;
        issue(CSR_W, CSR_MTVEC, val, 1'b0);
        read_csr(CSR_MTVEC);
        issue(CSR_S, CSR_MIE, lcg_next(), 1'b0);
        read_csr(CSR_MIE);
        issue(CSR_C, CSR_MIE, lcg_next(), 1'b0);
        read_csr(CSR_MIE);
        issue(CSR_W, CSR_MSCRATCH, lcg_next(), 1'b1);
        read_csr(CSR_MSCRATCH);
        end_test("write_read");

        begin_test();
        read_csr(CSR_MISA);
        read_csr(CSR_MHARTID);
        issue(CSR_W, CSR_MHARTID, lcg_next(), 1'b0);
        read_csr(CSR_MHARTID);
        end_test("read_only");

        begin_test();
        issue(CSR_ECALL, '0, '0, 1'b0);
        read_csr(CSR_MCAUSE);
        end_test("ecall");

        begin_test();
        // MPP = U, MIE and MPIE clear
        issue(CSR_W, CSR_MSTATUS, '0, 1'b0);
        issue(CSR_W, CSR_MEPC, lcg_next() & ~32'h3, 1'b0);
        issue(CSR_MRET, '0, '0, 1'b0);
        read_csr(CSR_MSTATUS);
        issue(CSR_ECALL, '0, '0, 1'b0);
        read_csr(CSR_MCAUSE);
        end_test("mret");

        begin_test();
        // Fresh trap target, differs from the one the last ECALL loaded
        issue(CSR_W, CSR_MTVEC, lcg_next() & ~32'h3, 1'b0);
        issue(CSR_S, CSR_MIE, 32'd1 << MIE_MTIE_BIT, 1'b0);
        // MIE set with MPIE clear and MPP = U
        issue(CSR_W, CSR_MSTATUS, 32'd1 << MSTATUS_MIE_BIT, 1'b0);
        @(posedge clk);
        #1;
        mtime    = 64'd100;
        mtimecmp = 64'd50;
        @(negedge clk);
        while (!stall_may_interrupt) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        // Read offered together with the interrupt is dropped
        interrupt_ready = 1'b1;
        fetch_pc        = lcg_next() & ~32'h3;
        csr_cmd         = CSR_S;
        csr_addr        = CSR_MSCRATCH;
        @(posedge clk);
        #1;
        interrupt_ready = 1'b0;
        csr_cmd         = CSR_X;
        csr_addr        = '0;
        read_csr(CSR_MCAUSE);
        read_csr(CSR_MEPC);
        read_csr(CSR_MSTATUS);
        read_csr(CSR_MIP);
        mtimecmp = '1;
        end_test("timer_irq");

        $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
